// File: hw/src_pkg.sv
`default_nettype none

package src_pkg;

    ////////////////////
    // sample and count widths
    ////////////////////

    localparam int SAMPLE_W = 24;   // signed audio sample
    localparam int COUNT_W  = 11;   // period / position, saturates at all ones
    localparam int OUT_W    = 36;   // unnormalized signed sum

    ////////////////////
    // output rate
    ////////////////////

    // 49.152 MHz / 512 = 96 kHz
    localparam int TICK_DIV = 512;
    localparam int TICK_W   = $clog2(TICK_DIV);

    ////////////////////
    // job buffer and flow control
    ////////////////////

    localparam int FIFO_DEPTH = 4;                    // jobs in flight between producer and consumer
    localparam int PTR_W      = $clog2(FIFO_DEPTH);   // depth is a power of two, pointers wrap
    localparam int CREDIT_W   = 3;                    // holds 0..FIFO_DEPTH
    localparam int DROP_W     = 8;

    // interpolation engine states
    localparam int          STATE_W    = 3;
    localparam logic [2:0]  ST_IDLE    = 3'd0;   // waiting for a job
    localparam logic [2:0]  ST_COEF    = 3'd1;   // period - pos
    localparam logic [2:0]  ST_MUL_OLD = 3'd2;   // older x (period - pos)
    localparam logic [2:0]  ST_MUL_NEW = 3'd3;   // newer x pos
    localparam logic [2:0]  ST_ADD     = 3'd4;   // sum of both products
    localparam logic [2:0]  ST_SUM     = 3'd5;   // sum presented, out_valid high

endpackage

`default_nettype wire

// File: hw/src_phase_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module src_phase_tracker (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                run,
    input  logic                                in_strobe,
    input  logic signed [src_pkg::SAMPLE_W-1:0] in_left,
    input  logic signed [src_pkg::SAMPLE_W-1:0] in_right,
    input  logic                                credit_return,
    output logic                                push,
    output logic signed [src_pkg::SAMPLE_W-1:0] job_left_old,
    output logic signed [src_pkg::SAMPLE_W-1:0] job_left_new,
    output logic signed [src_pkg::SAMPLE_W-1:0] job_right_old,
    output logic signed [src_pkg::SAMPLE_W-1:0] job_right_new,
    output logic        [src_pkg::COUNT_W-1:0]  job_pos,
    output logic        [src_pkg::COUNT_W-1:0]  job_period,
    output logic        [src_pkg::DROP_W-1:0]   drop_count
);
    import src_pkg::*;

    logic        [TICK_W-1:0]   tick_cnt;
    logic                       tick;
    logic        [COUNT_W-1:0]  pos_cnt;      // clocks since last strobe
    logic        [COUNT_W-1:0]  period;       // clocks between last two strobes
    logic        [1:0]          strobe_seen;
    logic                       primed;
    logic signed [SAMPLE_W-1:0] left_old, left_new;
    logic signed [SAMPLE_W-1:0] right_old, right_new;
    logic        [CREDIT_W-1:0] credit_cnt;
    logic                       has_credit;

    assign tick       = run && (tick_cnt == TICK_W'(TICK_DIV - 1));
    assign primed     = (strobe_seen == 2'd2);   // two strobes since run rose
    assign has_credit = (credit_cnt != '0);

    ////////////////////
    // output tick divider
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset || !run || tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    ////////////////////
    // input phase measurement
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset || !run) begin
            pos_cnt     <= '0;
            period      <= '0;
            strobe_seen <= '0;
        end else if (in_strobe) begin
            period  <= pos_cnt;   // latch before clearing
            pos_cnt <= '0;
            if (!primed) begin
                strobe_seen <= strobe_seen + 1'b1;
            end
        end else if (pos_cnt != '1) begin
            pos_cnt <= pos_cnt + 1'b1;   // saturating, source may stall
        end
    end

    // two-deep sample history per channel
    always_ff @(posedge clk) begin
        if (in_strobe) begin
            left_old  <= left_new;
            left_new  <= in_left;
            right_old <= right_new;
            right_new <= in_right;
        end
    end

    // job snapshot at the tick, pos clamped to period
    always_ff @(posedge clk) begin
        if (tick) begin
            job_left_old  <= left_old;
            job_left_new  <= left_new;
            job_right_old <= right_old;
            job_right_new <= right_new;
            job_pos       <= (pos_cnt > period) ? period : pos_cnt;
            job_period    <= period;
        end
    end

    ////////////////////
    // credits and drops
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset || !run) begin
            push       <= 1'b0;
            drop_count <= '0;
        end else begin
            push <= tick && primed && has_credit;   // one cycle after the tick
            if (tick && primed && !has_credit && (drop_count != '1)) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || !run) begin
            credit_cnt <= CREDIT_W'(FIFO_DEPTH);
        end else begin
            case ({push, credit_return})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;   // none, or spend and return together
            endcase
        end
    end

    a_push_has_credit: assert property (@(posedge clk) disable iff (reset)
        push |-> has_credit)
        else $error("push issued with no credit left");

    // returns can never outrun what the buffer holds
    a_credit_bound: assert property (@(posedge clk) disable iff (reset)
        credit_cnt <= CREDIT_W'(FIFO_DEPTH))
        else $error("credit count above buffer depth");

endmodule

`default_nettype wire

// File: hw/src_job_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module src_job_fifo (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                run,
    input  logic                                push,
    input  logic signed [src_pkg::SAMPLE_W-1:0] job_left_old,
    input  logic signed [src_pkg::SAMPLE_W-1:0] job_left_new,
    input  logic signed [src_pkg::SAMPLE_W-1:0] job_right_old,
    input  logic signed [src_pkg::SAMPLE_W-1:0] job_right_new,
    input  logic        [src_pkg::COUNT_W-1:0]  job_pos,
    input  logic        [src_pkg::COUNT_W-1:0]  job_period,
    output logic                                job_avail,
    output logic signed [src_pkg::SAMPLE_W-1:0] head_left_old,
    output logic signed [src_pkg::SAMPLE_W-1:0] head_left_new,
    output logic signed [src_pkg::SAMPLE_W-1:0] head_right_old,
    output logic signed [src_pkg::SAMPLE_W-1:0] head_right_new,
    output logic        [src_pkg::COUNT_W-1:0]  head_pos,
    output logic        [src_pkg::COUNT_W-1:0]  head_period,
    output logic                                credit_return,
    input  logic                                pop
);
    import src_pkg::*;

    logic signed [SAMPLE_W-1:0] mem_left_old  [FIFO_DEPTH];
    logic signed [SAMPLE_W-1:0] mem_left_new  [FIFO_DEPTH];
    logic signed [SAMPLE_W-1:0] mem_right_old [FIFO_DEPTH];
    logic signed [SAMPLE_W-1:0] mem_right_new [FIFO_DEPTH];
    logic        [COUNT_W-1:0]  mem_pos       [FIFO_DEPTH];
    logic        [COUNT_W-1:0]  mem_period    [FIFO_DEPTH];
    logic        [PTR_W-1:0]    wr_ptr, rd_ptr;
    logic        [CREDIT_W-1:0] count;   // occupancy 0..FIFO_DEPTH
    logic                       full;

    assign full      = (count == CREDIT_W'(FIFO_DEPTH));
    assign job_avail = (count != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem_left_old[wr_ptr]  <= job_left_old;
            mem_left_new[wr_ptr]  <= job_left_new;
            mem_right_old[wr_ptr] <= job_right_old;
            mem_right_new[wr_ptr] <= job_right_new;
            mem_pos[wr_ptr]       <= job_pos;
            mem_period[wr_ptr]    <= job_period;
        end
    end

    // pointers, occupancy and credit pulse, all cleared while run is low
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;   // natural wrap
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit_return <= pop;   // one cycle after the pop
        end
    end

    // show-ahead head
    assign head_left_old  = mem_left_old[rd_ptr];
    assign head_left_new  = mem_left_new[rd_ptr];
    assign head_right_old = mem_right_old[rd_ptr];
    assign head_right_new = mem_right_new[rd_ptr];
    assign head_pos       = mem_pos[rd_ptr];
    assign head_period    = mem_period[rd_ptr];

    a_no_push_full: assert property (@(posedge clk) disable iff (reset)
        push |-> !full)
        else $error("job pushed into a full buffer");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        pop |-> job_avail)
        else $error("job popped from an empty buffer");

endmodule

`default_nettype wire

// File: hw/src_interp_engine.sv
`timescale 1ns/1ns
`default_nettype none

module src_interp_engine (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                hold,
    input  logic                                job_avail,
    input  logic signed [src_pkg::SAMPLE_W-1:0] head_left_old,
    input  logic signed [src_pkg::SAMPLE_W-1:0] head_left_new,
    input  logic signed [src_pkg::SAMPLE_W-1:0] head_right_old,
    input  logic signed [src_pkg::SAMPLE_W-1:0] head_right_new,
    input  logic        [src_pkg::COUNT_W-1:0]  head_pos,
    input  logic        [src_pkg::COUNT_W-1:0]  head_period,
    output logic                                pop,
    output logic                                out_valid,
    output logic signed [src_pkg::OUT_W-1:0]    out_left,
    output logic signed [src_pkg::OUT_W-1:0]    out_right
);
    import src_pkg::*;

    logic        [STATE_W-1:0]      state;
    logic signed [SAMPLE_W-1:0]     old_left, new_left, old_right, new_right;
    logic        [COUNT_W-1:0]      pos_r, period_r;
    logic        [COUNT_W-1:0]      coef;   // shared by both channels
    logic signed [SAMPLE_W-1:0]     mult_left, mult_right;
    logic signed [SAMPLE_W+COUNT_W:0] mult_left_p, mult_right_p;
    logic signed [OUT_W-1:0]        prod_left, prod_right;
    logic signed [OUT_W-1:0]        acc_left, acc_right;

    // start a job only from idle, hold stalls the start
    assign pop = (state == ST_IDLE) && !hold && job_avail;

    // coefficient is unsigned, zero bit keeps it positive
    assign mult_left_p  = mult_left * $signed({1'b0, coef});
    assign mult_right_p = mult_right * $signed({1'b0, coef});

    ////////////////////
    // sequencer
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (pop) begin
                        state <= ST_COEF;
                    end
                end
                ST_COEF:    state <= ST_MUL_OLD;
                ST_MUL_OLD: state <= ST_MUL_NEW;
                ST_MUL_NEW: state <= ST_ADD;
                ST_ADD: begin
                    state     <= ST_SUM;
                    out_valid <= 1'b1;   // 5th cycle after pop
                end
                ST_SUM:     state <= ST_IDLE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    ////////////////////
    // datapath
    ////////////////////

    always_ff @(posedge clk) begin
        case (state)
            ST_IDLE: begin
                if (pop) begin   // take the head job
                    old_left  <= head_left_old;
                    new_left  <= head_left_new;
                    old_right <= head_right_old;
                    new_right <= head_right_new;
                    pos_r     <= head_pos;
                    period_r  <= head_period;
                end
            end
            ST_COEF: begin
                coef       <= period_r - pos_r;   // pos never exceeds period
                mult_left  <= old_left;
                mult_right <= old_right;
            end
            ST_MUL_OLD: begin
                prod_left  <= OUT_W'(mult_left_p);    // older x (period - pos)
                prod_right <= OUT_W'(mult_right_p);
                coef       <= pos_r;
                mult_left  <= new_left;
                mult_right <= new_right;
            end
            ST_MUL_NEW: begin
                acc_left   <= prod_left;
                acc_right  <= prod_right;
                prod_left  <= OUT_W'(mult_left_p);    // newer x pos
                prod_right <= OUT_W'(mult_right_p);
            end
            ST_ADD: begin
                out_left  <= acc_left + prod_left;
                out_right <= acc_right + prod_right;
            end
            default: begin
            end
        endcase
    end

    a_valid_in_sum: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> (state == ST_SUM))
        else $error("out_valid outside the sum state");

endmodule

`default_nettype wire

// File: hw/src_top.sv
`timescale 1ns/1ns
`default_nettype none

module src_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                run,
    input  logic                                in_strobe,
    input  logic signed [src_pkg::SAMPLE_W-1:0] in_left,
    input  logic signed [src_pkg::SAMPLE_W-1:0] in_right,
    input  logic                                hold,
    output logic                                out_valid,
    output logic signed [src_pkg::OUT_W-1:0]    out_left,
    output logic signed [src_pkg::OUT_W-1:0]    out_right,
    output logic        [src_pkg::DROP_W-1:0]   drop_count
);
    import src_pkg::*;

    // producer to buffer
    logic                       push;
    logic signed [SAMPLE_W-1:0] job_left_old, job_left_new;
    logic signed [SAMPLE_W-1:0] job_right_old, job_right_new;
    logic        [COUNT_W-1:0]  job_pos, job_period;
    logic                       credit_return;

    // buffer to consumer
    logic                       job_avail, pop;
    logic signed [SAMPLE_W-1:0] head_left_old, head_left_new;
    logic signed [SAMPLE_W-1:0] head_right_old, head_right_new;
    logic        [COUNT_W-1:0]  head_pos, head_period;

    src_phase_tracker i_phase_tracker (
        .clk           (clk),
        .reset         (reset),
        .run           (run),
        .in_strobe     (in_strobe),
        .in_left       (in_left),
        .in_right      (in_right),
        .credit_return (credit_return),
        .push          (push),
        .job_left_old  (job_left_old),
        .job_left_new  (job_left_new),
        .job_right_old (job_right_old),
        .job_right_new (job_right_new),
        .job_pos       (job_pos),
        .job_period    (job_period),
        .drop_count    (drop_count)
    );

    src_job_fifo i_job_fifo (
        .clk            (clk),
        .reset          (reset),
        .run            (run),
        .push           (push),
        .job_left_old   (job_left_old),
        .job_left_new   (job_left_new),
        .job_right_old  (job_right_old),
        .job_right_new  (job_right_new),
        .job_pos        (job_pos),
        .job_period     (job_period),
        .job_avail      (job_avail),
        .head_left_old  (head_left_old),
        .head_left_new  (head_left_new),
        .head_right_old (head_right_old),
        .head_right_new (head_right_new),
        .head_pos       (head_pos),
        .head_period    (head_period),
        .credit_return  (credit_return),
        .pop            (pop)
    );

    // hold is the only back-pressure, downstream has no ready
    src_interp_engine i_interp_engine (
        .clk            (clk),
        .reset          (reset),
        .hold           (hold),
        .job_avail      (job_avail),
        .head_left_old  (head_left_old),
        .head_left_new  (head_left_new),
        .head_right_old (head_right_old),
        .head_right_new (head_right_new),
        .head_pos       (head_pos),
        .head_period    (head_period),
        .pop            (pop),
        .out_valid      (out_valid),
        .out_left       (out_left),
        .out_right      (out_right)
    );

endmodule

`default_nettype wire

// File: dv/src_tb.sv
`timescale 1ns/1ns
`default_nettype none

module src_tb;
    import src_pkg::*;

    localparam VEC_FILE  = "dv/src_vectors.txt";
    localparam int VEC_WORDS = 256;   // four words per record
    localparam int SEED      = 16971;
    localparam int COUNT_MAX = (1 << COUNT_W) - 1;
    localparam int DROP_MAX  = (1 << DROP_W) - 1;

    logic                       clk;
    logic                       reset;
    logic                       run;
    logic                       in_strobe;
    logic signed [SAMPLE_W-1:0] in_left;
    logic signed [SAMPLE_W-1:0] in_right;
    logic                       hold = 1'b0;
    logic                       out_valid;
    logic signed [OUT_W-1:0]    out_left;
    logic signed [OUT_W-1:0]    out_right;
    logic        [DROP_W-1:0]   drop_count;

    logic [31:0] vec [VEC_WORDS];   // op, gap or count, left, right

    // reference model of the producer side
    int edge_no = 0;
    int run_edges = 0;
    int last_strobe = 0;
    int period = 0;
    int seen = 0;         // strobes since run rose, stops at 2
    int drops = 0;
    int jobs_made = 0;
    int outputs_seen = 0;
    int hold_req = 0;     // ticks asked for, not yet started
    int hold_left = 0;
    logic hold_next = 1'b0;
    logic signed [SAMPLE_W-1:0] m_left_old, m_left_new, m_right_old, m_right_new;
    logic signed [OUT_W-1:0]    exp_left_q[$];
    logic signed [OUT_W-1:0]    exp_right_q[$];

    int errors = 0;
    int tests = 0;
    int test_outputs = 0;
    int cycle_count = 0;
    int cycle_limit = 0;
    int gaps_used[$];     // jittered gaps as driven

    src_top i_src_top (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .in_strobe  (in_strobe),
        .in_left    (in_left),
        .in_right   (in_right),
        .hold       (hold),
        .out_valid  (out_valid),
        .out_left   (out_left),
        .out_right  (out_right),
        .drop_count (drop_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    ////////////////////
    // expected values
    ////////////////////

    function automatic int clamp_count(input int n);
        return (n > COUNT_MAX) ? COUNT_MAX : n;   // counters stop at all ones
    endfunction

    // older x (period - pos) + newer x pos
    function automatic logic signed [OUT_W-1:0] interpolate(
        input logic signed [SAMPLE_W-1:0] older,
        input logic signed [SAMPLE_W-1:0] newer,
        input int                         per,
        input int                         pos
    );
        longint acc;
        acc = longint'(older) * (per - pos) + longint'(newer) * pos;
        return OUT_W'(acc);
    endfunction

    task automatic take_tick();
        int pos;
        if (seen >= 2) begin
            pos = clamp_count(edge_no - last_strobe - 1);
            if (pos > period) begin
                pos = period;   // source stalled
            end
            if (jobs_made - outputs_seen < FIFO_DEPTH) begin
                exp_left_q.push_back(interpolate(m_left_old, m_left_new, period, pos));
                exp_right_q.push_back(interpolate(m_right_old, m_right_new, period, pos));
                jobs_made++;
            end else if (drops < DROP_MAX) begin
                drops++;   // all credits out
            end
        end
        // hold windows open and close right after a tick
        if (hold_req > 0 && !hold_next) begin
            hold_next = 1'b1;
            hold_left = hold_req;
            hold_req  = 0;
        end else if (hold_next) begin
            hold_left--;
            if (hold_left == 0) begin
                hold_next = 1'b0;
            end
        end
    endtask

    task automatic take_strobe();
        period      = clamp_count(edge_no - last_strobe - 1);   // clocks strictly between
        last_strobe = edge_no;
        m_left_old  = m_left_new;
        m_left_new  = in_left;
        m_right_old = m_right_new;
        m_right_new = in_right;
        if (seen < 2) begin
            seen++;
        end
    endtask

    // inputs are stable here, they move 1 ns after the edge
    always @(posedge clk) begin
        edge_no++;
        if (reset || !run) begin
            run_edges   = 0;
            seen        = 0;
            period      = 0;
            drops       = 0;
            last_strobe = edge_no;   // position counts from run rising
            hold_req    = 0;
            hold_next   = 1'b0;
            hold_left   = 0;
            jobs_made   = outputs_seen;   // held jobs leave with the buffer
            exp_left_q.delete();
            exp_right_q.delete();
        end else begin
            run_edges++;
            if (run_edges % TICK_DIV == 0) begin
                take_tick();   // snapshot before any strobe at the same edge
            end
            if (in_strobe) begin
                take_strobe();
            end
        end
    end

    always @(posedge clk) begin
        #1;
        hold = hold_next;
    end

    ////////////////////
    // checks
    ////////////////////

    task automatic check_sample(
        input string                   name,
        input logic signed [OUT_W-1:0] exp_v,
        input logic signed [OUT_W-1:0] act_v
    );
        if (act_v !== exp_v) begin
            errors++;
            $display("mismatch at %0t ns: %s expected %0d, actual %0d", $time, name, exp_v, act_v);
        end
    endtask

    task automatic check_count(
        input string              name,
        input logic [DROP_W-1:0]  exp_v,
        input logic [DROP_W-1:0]  act_v
    );
        if (act_v !== exp_v) begin
            errors++;
            $display("mismatch at %0t ns: %s expected %0d, actual %0d", $time, name, exp_v, act_v);
        end
    endtask

    // outputs settle after the rising edge
    always @(negedge clk) begin
        if (out_valid === 1'b1) begin
            if (reset) begin
                errors++;
                $display("out_valid raised during reset at %0t ns", $time);
            end else if (exp_left_q.size() == 0) begin
                errors++;
                $display("out_valid at %0t ns with no job expected", $time);
            end else begin
                check_sample("out_left", exp_left_q.pop_front(), out_left);
                check_sample("out_right", exp_right_q.pop_front(), out_right);
                outputs_seen++;
                test_outputs++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run not finished after %0d cycles", cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    task automatic pulse_strobe(
        input int                         gap,
        input logic signed [SAMPLE_W-1:0] l,
        input logic signed [SAMPLE_W-1:0] r
    );
        repeat (gap - 1) @(posedge clk);
        #1;
        in_strobe = 1'b1;
        in_left   = l;
        in_right  = r;
        @(posedge clk);
        #1;
        in_strobe = 1'b0;
    endtask

    task automatic wait_drained();
        do begin
            @(posedge clk);
            #1;
        end while (hold_next || hold_req != 0 || jobs_made != outputs_seen);
    endtask

    task automatic cycle_run(input int low_cycles);
        hold_req = FIFO_DEPTH + 1;   // window outlasts the fill
        // buffer full and held, credits all spent, well clear of any tick
        do begin
            @(posedge clk);
            #1;
        end while (jobs_made - outputs_seen != FIFO_DEPTH || run_edges % TICK_DIV != 100);
        run = 1'b0;
        repeat (low_cycles) @(posedge clk);
        #1;
        run = 1'b1;
    endtask

    initial begin
        int          idx;
        int          g;
        int          sum_gaps;
        int          test_errors;
        logic [31:0] op, a, b, c;
        reset     = 1'b1;
        run       = 1'b0;
        in_strobe = 1'b0;
        in_left   = '0;
        in_right  = '0;
        void'($urandom(SEED));
        $readmemh(VEC_FILE, vec);

        // run length from the vectors, for the timeout
        idx      = 0;
        sum_gaps = 0;
        while (idx < VEC_WORDS && vec[idx] != 0) begin
            case (vec[idx])
                1: sum_gaps += vec[idx+1] + 3;
                2: sum_gaps += (vec[idx+1] + 1) * TICK_DIV;
                3: sum_gaps += vec[idx+1];
                4: sum_gaps += vec[idx+1] + (FIFO_DEPTH + 1) * TICK_DIV;
                5: sum_gaps += TICK_DIV;   // drain
                default: ;
            endcase
            idx += 4;
        end
        cycle_limit = 2 * sum_gaps + TICK_DIV * (sum_gaps / TICK_DIV + 1) + 64;

        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        @(posedge clk);
        #1 run = 1'b1;

        idx         = 0;
        test_errors = 0;
        while (idx < VEC_WORDS && vec[idx] != 0) begin
            op = vec[idx];
            a  = vec[idx+1];
            b  = vec[idx+2];
            c  = vec[idx+3];
            case (op)
                1: begin
                    g = int'(a) + int'($urandom_range(6, 0)) - 3;   // +-3 clocks
                    gaps_used.push_back(g);
                    pulse_strobe(g, b[SAMPLE_W-1:0], c[SAMPLE_W-1:0]);
                end
                2: hold_req = a;
                3: begin
                    repeat (a) @(posedge clk);
                    #1;
                end
                4: cycle_run(a);
                5: begin
                    wait_drained();
                    @(negedge clk);
                    check_count("drop_count", b[DROP_W-1:0], drop_count);
                    check_count("drop_count", DROP_W'(drops), drop_count);
                    if (test_outputs == 0) begin
                        errors++;
                        $display("test %0d produced no output", a);
                    end
                    $display("test %0d done: %0d outputs, %0d errors", a, test_outputs,
                             errors - test_errors);
                    tests++;
                    test_outputs = 0;
                    test_errors  = errors;
                end
                default: begin
                    errors++;
                    $display("unknown vector op %0h in record %0d", op, idx / 4);
                end
            endcase
            idx += 4;
        end

        $display("%0d tests, %0d outputs checked, %0d strobes, %0d errors",
                 tests, outputs_seen, gaps_used.size(), errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/src_vectors.txt
// op gap_or_count left right, hex, one record per line
// op 1 strobe after gap, 2 hold n ticks, 3 stall n clocks, 4 run low n, 5 end test n drops, 0 end
// test 1: priming, steady gaps, signed extremes
1 1d6 000000 000000
1 1d6 7fffff 800000
1 1d6 800000 7fffff
1 1d6 7fffff 7fffff
1 1d6 800000 800000
1 1d6 000001 ffffff
1 1d6 123456 edcba9
1 1d6 400000 c00000
5 1 0 0
// test 2: source stalls past the period
1 1d6 2aaaaa d55556
1 1d6 3fffff c00001
3 514 0 0
1 1d6 7ffffe 800001
1 1d6 010203 fefdfc
1 1d6 0fffff f00000
5 2 0 0
// test 3: hold for six ticks, four jobs queue, three drops
2 6 0 0
1 1d6 111111 eeeeef
1 1d6 222222 dddddd
1 1d6 333333 cccccd
1 1d6 7fffff 800000
1 1d6 555555 aaaaab
1 1d6 800000 7fffff
1 1d6 070707 f8f8f9
1 1d6 654321 9abcdf
1 1d6 00ff00 ff00ff
5 3 3 0
// test 4: run cycled, drop count cleared, priming again
4 14 0 0
1 1d6 246800 dbb800
1 1d6 7fffff 800000
1 1d6 135790 eca870
1 1d6 800000 7fffff
5 4 0 0
0 0 0 0

// File: verilog.f
hw/src_pkg.sv
hw/src_phase_tracker.sv
hw/src_job_fifo.sv
hw/src_interp_engine.sv
hw/src_top.sv
dv/src_tb.sv
